//--- st_io_bridge.f
io_cfg_pkg.sv
io_xfer_pkg.sv
io_fifo.sv
parallel_port.sv
fifo_arbiter.sv
st_io_bridge.sv
tb_st_io_bridge.sv

//--- Bender.yml
package:
  name: st_io_bridge

dependencies: {}

sources:
  - io_cfg_pkg.sv
  - io_xfer_pkg.sv
  - io_fifo.sv
  - parallel_port.sv
  - fifo_arbiter.sv
  - st_io_bridge.sv
  - target: simulation
    files:
      - tb_st_io_bridge.sv

//--- tb_st_io_bridge.sv
// ----------------------------------------------------------------------
// Random self-checking testbench with host acks after 0 to 5 cycles
// Inputs driven and outputs sampled on the falling edge of clk_32
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_st_io_bridge;
	import io_cfg_pkg::*;
	import io_xfer_pkg::*;

	localparam int N_BURSTS = 5;  // MIDI bursts in the order test

	logic       clk_32 = 1'b0;
	logic       rst_n;
	ctrl_word_t system_ctrl;
	logic       midi_out_strobe;
	byte_t      midi_out;
	logic       parallel_out_strobe;
	byte_t      parallel_out;
	joy_t       joy2;
	joy_t       joy3;
	byte_t      parallel_in;
	logic       parallel_in_strobe;
	logic       parallel_printer_busy;
	logic       host_req;
	logic       host_ack;
	byte_t      host_data;
	chan_e      host_chan;

	logic [31:0] rng = 32'd63367;
	logic [31:0] ack_rng = ~32'd63367;  // Separate stream for ack delays
	logic        host_en = 1'b0;        // Host responder active
	string       test_name = "reset";
	int          val_errs = 0;
	int          other_errs = 0;
	int          cycles = 0;
	int          cycle_limit;
	int          burst_len [N_BURSTS];
	byte_t       exp_midi [$];          // Model with one queue per channel
	byte_t       exp_par [$];
	byte_t       log_data [$];          // Everything the host received
	chan_e       log_chan [$];

	st_io_bridge dut (
		.clk_32 ( clk_32 ), .rst_n ( rst_n ), .system_ctrl ( system_ctrl ),
		.midi_out_strobe ( midi_out_strobe ), .midi_out ( midi_out ),
		.parallel_out_strobe ( parallel_out_strobe ), .parallel_out ( parallel_out ),
		.joy2 ( joy2 ), .joy3 ( joy3 ),
		.parallel_in ( parallel_in ), .parallel_in_strobe ( parallel_in_strobe ),
		.parallel_printer_busy ( parallel_printer_busy ),
		.host_req ( host_req ), .host_ack ( host_ack ),
		.host_data ( host_data ), .host_chan ( host_chan )
	);

	always #20 clk_32 = ~clk_32;  // 40 ns period

	// Run limit sized from the bytes planned at time 0
	always @(posedge clk_32) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles in %s, the run did not finish",
				cycles, test_name);
			$display("Errors: %0d value, %0d other", val_errs, other_errs + 1);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] next_rand();
		rng = lcg_step(rng);
		return rng[31:16];  // Upper bits have the longer period
	endfunction

	// Inverted bit 0 of each joystick lands in its nibble MSB
	function automatic byte_t expected_pins(input joy_t j2, input joy_t j3);
		byte_t p;
		int    b;
		for (b = 0; b < 4; b++) begin
			p[7-b] = ~j2[b];
			p[3-b] = ~j3[b];
		end
		return p;
	endfunction

	task automatic report_mismatch(input logic [31:0] exp_v, input logic [31:0] act_v);
		val_errs++;
		$display("** Error %s: expected %0h, actual %0h", test_name, exp_v, act_v);
	endtask

	// One four-phase transfer with the byte checked against the model queue
	task automatic serve_byte();
		byte_t d;
		byte_t e;
		chan_e c;
		int    delay;
		d = host_data;
		c = host_chan;
		log_data.push_back(d);
		log_chan.push_back(c);
		if ((c == CH_MIDI && exp_midi.size() == 0) ||
		    (c == CH_PAR && exp_par.size() == 0)) begin
			other_errs++;
			$display("%s: byte %h on channel %s arrived but none was pending",
				test_name, d, c.name());
		end else begin
			if (c == CH_MIDI)
				e = exp_midi.pop_front();
			else
				e = exp_par.pop_front();
			if (d !== e)
				report_mismatch(e, d);
		end
		ack_rng = lcg_step(ack_rng);
		delay = ack_rng[31:16] % 6;
		repeat (delay) @(negedge clk_32);
		host_ack = 1'b1;
		do @(negedge clk_32); while (host_req);  // Wait for req to drop
		host_ack = 1'b0;
	endtask

	always begin
		@(negedge clk_32);
		if (host_en && host_req && !host_ack)
			serve_byte();
	end

	// Host enable flips on the rising edge away from the responder
	task automatic set_host(input logic en);
		@(posedge clk_32);
		host_en = en;
	endtask

	task automatic wait_drain();
		do @(negedge clk_32);
		while (exp_midi.size() != 0 || exp_par.size() != 0 || host_req || host_ack);
	endtask

	task automatic pulse_flush();
		@(negedge clk_32);
		system_ctrl[CTRL_RESET_BIT] = 1'b1;
		@(negedge clk_32);
		system_ctrl[CTRL_RESET_BIT] = 1'b0;
	endtask

	// n writes to both FIFOs in the same cycles
	task automatic load_both(input int n);
		repeat (n) begin
			@(negedge clk_32);
			midi_out_strobe     = 1'b1;
			midi_out            = byte_t'(next_rand());
			parallel_out_strobe = 1'b1;
			parallel_out        = byte_t'(next_rand());
			exp_midi.push_back(midi_out);
			exp_par.push_back(parallel_out);
		end
		@(negedge clk_32);
		midi_out_strobe     = 1'b0;
		parallel_out_strobe = 1'b0;
	endtask

	initial begin
		int    total;
		int    first;
		int    i;
		int    b;
		logic  busy_exp;
		chan_e ch_exp;
		rst_n               = 1'b0;
		system_ctrl         = '0;
		midi_out_strobe     = 1'b0;
		midi_out            = '0;
		parallel_out_strobe = 1'b0;
		parallel_out        = '0;
		joy2                = '0;
		joy3                = '0;
		host_ack            = 1'b0;

		total = (PAR_FIFO_DEPTH + 1) + 6 + 6;  // Printer, round robin, flush
		for (b = 0; b < N_BURSTS; b++) begin
			burst_len[b] = 1 + next_rand() % MIDI_FIFO_DEPTH;
			total += burst_len[b];
		end
		cycle_limit = 20 * total + 200;

		repeat (2) @(negedge clk_32);
		rst_n = 1'b1;

		// Busy follows joy2 fire without redirection
		@(negedge clk_32);
		if (host_req !== 1'b0)
			report_mismatch(0, host_req);
		for (i = 0; i < 8; i++) begin
			joy2 = next_rand();
			@(negedge clk_32);
			if (parallel_printer_busy !== joy2[JOY_FIRE_BIT])
				report_mismatch(joy2[JOY_FIRE_BIT], parallel_printer_busy);
		end

		test_name = "midi order";
		set_host(1'b1);
		for (b = 0; b < N_BURSTS; b++) begin
			for (i = 0; i < burst_len[b]; i++) begin
				@(negedge clk_32);
				midi_out_strobe = 1'b1;
				midi_out        = byte_t'(next_rand());
				exp_midi.push_back(midi_out);
			end
			@(negedge clk_32);
			midi_out_strobe = 1'b0;
			wait_drain();
		end

		// Arbiter holds one byte so the FIFO fills on the last write
		test_name = "printer busy";
		set_host(1'b0);
		@(negedge clk_32);
		system_ctrl[CTRL_REDIR_LSB +: 2] = REDIR_PRINTER;
		@(negedge clk_32);
		if (parallel_printer_busy !== 1'b0)
			report_mismatch(0, parallel_printer_busy);
		for (i = 1; i <= PAR_FIFO_DEPTH + 1; i++) begin
			parallel_out_strobe = 1'b1;
			parallel_out        = byte_t'(next_rand());
			exp_par.push_back(parallel_out);
			@(negedge clk_32);
			parallel_out_strobe = 1'b0;
			busy_exp = (i == PAR_FIFO_DEPTH + 1);
			if (parallel_printer_busy !== busy_exp)
				report_mismatch(busy_exp, parallel_printer_busy);
			@(negedge clk_32);  // Idle cycle between writes
		end
		set_host(1'b1);
		wait_drain();
		if (parallel_printer_busy !== 1'b0)
			report_mismatch(0, parallel_printer_busy);

		// After a flush MIDI counts as served last
		test_name = "round robin";
		system_ctrl[CTRL_REDIR_LSB +: 2] = REDIR_NONE;
		set_host(1'b0);
		pulse_flush();
		load_both(3);
		first = log_chan.size();
		set_host(1'b1);
		wait_drain();
		if (log_chan.size() - first != 6) begin
			other_errs++;
			$display("round robin: %0d bytes arrived instead of 6", log_chan.size() - first);
		end else begin
			for (i = 0; i < 6; i++) begin
				ch_exp = (i % 2 == 0) ? CH_PAR : CH_MIDI;
				if (log_chan[first + i] !== ch_exp)
					report_mismatch(ch_exp, log_chan[first + i]);
			end
		end

		test_name = "joystick pins";
		for (i = 0; i < 16; i++) begin
			joy2 = next_rand();
			joy3 = next_rand();
			@(negedge clk_32);
			if (parallel_in !== expected_pins(joy2, joy3))
				report_mismatch(expected_pins(joy2, joy3), parallel_in);
			if (parallel_in_strobe !== !joy3[JOY_FIRE_BIT])
				report_mismatch(!joy3[JOY_FIRE_BIT], parallel_in_strobe);
		end

		// Core reset with both FIFOs loaded and req pending
		test_name = "flush";
		set_host(1'b0);
		load_both(3);
		@(negedge clk_32);
		if (host_req !== 1'b1)
			report_mismatch(1, host_req);
		pulse_flush();
		if (host_req !== 1'b0)
			report_mismatch(0, host_req);
		exp_midi.delete();
		exp_par.delete();
		first = log_data.size();
		set_host(1'b1);
		repeat (20) @(negedge clk_32);
		if (log_data.size() != first) begin
			other_errs++;
			$display("flush: %0d bytes arrived after the flush", log_data.size() - first);
		end

		$display("Errors: %0d value, %0d other", val_errs, other_errs);
		if (val_errs + other_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- st_io_bridge.sv
// ----------------------------------------------------------------------
// Byte transfer glue between ST character ports and the io controller
// Control word assumed stable in the single clk_32 domain
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module st_io_bridge import io_cfg_pkg::*, io_xfer_pkg::*; (
	input  logic       clk_32,
	input  logic       rst_n,
	input  ctrl_word_t system_ctrl,
	input  logic       midi_out_strobe,      // ACIA data register write
	input  byte_t      midi_out,
	input  logic       parallel_out_strobe,  // PSG printer write
	input  byte_t      parallel_out,
	input  joy_t       joy2,
	input  joy_t       joy3,
	output byte_t      parallel_in,
	output logic       parallel_in_strobe,
	output logic       parallel_printer_busy,
	output logic       host_req,
	input  logic       host_ack,
	output byte_t      host_data,
	output chan_e      host_chan
);

	logic   flush;
	redir_e redir;
	logic   midi_avail;
	logic   midi_pop;
	byte_t  midi_head;
	logic   par_avail;
	logic   par_pop;
	byte_t  par_head;

	assign flush = system_ctrl[CTRL_RESET_BIT];
	assign redir = redir_e'(system_ctrl[CTRL_REDIR_LSB +: $bits(redir_e)]);

	// MIDI output FIFO filled alongside the real UART
	io_fifo #(
		.DEPTH ( MIDI_FIFO_DEPTH )
	) u_midi_fifo (
		.clk_32 ( clk_32 ), .rst_n ( rst_n ), .flush ( flush ),
		.wr     ( midi_out_strobe ),
		.din    ( midi_out        ),
		.pop    ( midi_pop        ),
		.head   ( midi_head       ),
		.avail  ( midi_avail      ),
		.full   (                 )  // MIDI has no back-pressure
	);

	parallel_port u_par (
		.clk_32 ( clk_32 ), .rst_n ( rst_n ), .flush ( flush ),
		.redir ( redir ), .parallel_out_strobe ( parallel_out_strobe ),
		.parallel_out ( parallel_out ), .joy2 ( joy2 ), .joy3 ( joy3 ),
		.pop ( par_pop ), .head ( par_head ), .avail ( par_avail ),
		.parallel_printer_busy ( parallel_printer_busy ),
		.parallel_in ( parallel_in ), .parallel_in_strobe ( parallel_in_strobe )
	);

	fifo_arbiter u_arb (
		.clk_32 ( clk_32 ), .rst_n ( rst_n ), .flush ( flush ),
		.midi_avail ( midi_avail ), .midi_head ( midi_head ), .midi_pop ( midi_pop ),
		.par_avail ( par_avail ), .par_head ( par_head ), .par_pop ( par_pop ),
		.host_req ( host_req ), .host_ack ( host_ack ),
		.host_data ( host_data ), .host_chan ( host_chan )
	);

endmodule

//--- fifo_arbiter.sv
// ----------------------------------------------------------------------
// Round-robin drain of two FIFOs onto a four-phase req/ack byte channel
// Holds one popped byte, host must drop ack before the next request
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module fifo_arbiter import io_cfg_pkg::*, io_xfer_pkg::*; (
	input  logic  clk_32,
	input  logic  rst_n,
	input  logic  flush,
	input  logic  midi_avail,
	input  byte_t midi_head,
	output logic  midi_pop,
	input  logic  par_avail,
	input  byte_t par_head,
	output logic  par_pop,
	output logic  host_req,
	input  logic  host_ack,
	output byte_t host_data,
	output chan_e host_chan
);

	arb_state_e state;
	chan_e      last_served;  // Channel granted most recently
	chan_e      grant;
	logic       any_avail;
	logic       take;         // Pop and latch this cycle

	assign any_avail = midi_avail | par_avail;

	// Tie goes to the channel not served last
	always_comb begin
		if (midi_avail && par_avail)
			grant = (last_served == CH_MIDI) ? CH_PAR : CH_MIDI;
		else if (midi_avail)
			grant = CH_MIDI;
		else
			grant = CH_PAR;
	end

	assign take     = (state == ARB_IDLE) && any_avail;
	assign midi_pop = take && (grant == CH_MIDI);
	assign par_pop  = take && (grant == CH_PAR);

	assign host_req = (state == ARB_REQ);  // Decoded from state register

	// Handshake FSM
	always_ff @(posedge clk_32) begin
		if (!rst_n || flush) begin
			state       <= ARB_IDLE;
			last_served <= CH_MIDI;  // First tie goes to parallel
		end else begin
			case (state)
				ARB_IDLE: begin
					if (any_avail) begin
						state       <= ARB_REQ;
						last_served <= grant;
					end
				end
				ARB_REQ: begin
					if (host_ack)
						state <= ARB_RELEASE;  // Phase 3, drop req
				end
				ARB_RELEASE: begin
					if (!host_ack)
						state <= ARB_IDLE;     // Phase 4 done
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Byte and tag held stable while req is high
	always_ff @(posedge clk_32) begin
		if (take) begin
			host_data <= (grant == CH_MIDI) ? midi_head : par_head;
			host_chan <= grant;
		end
	end

endmodule

//--- parallel_port.sv
// ----------------------------------------------------------------------
// Printer FIFO plus gauntlet style joystick adapter on the parallel port
// Busy and packed inputs are combinational, no synchronizers on joysticks
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module parallel_port import io_cfg_pkg::*; (
	input  logic   clk_32,
	input  logic   rst_n,
	input  logic   flush,
	input  redir_e redir,                // USB redirection field
	input  logic   parallel_out_strobe,  // CPU write to printer data
	input  byte_t  parallel_out,
	input  joy_t   joy2,
	input  joy_t   joy3,
	input  logic   pop,                  // From arbiter
	output byte_t  head,
	output logic   avail,
	output logic   parallel_printer_busy,
	output byte_t  parallel_in,
	output logic   parallel_in_strobe
);

	logic fifo_full;

	io_fifo #(
		.DEPTH ( PAR_FIFO_DEPTH )
	) u_par_fifo (
		.clk_32 ( clk_32              ),
		.rst_n  ( rst_n               ),
		.flush  ( flush               ),
		.wr     ( parallel_out_strobe ),
		.din    ( parallel_out        ),
		.pop    ( pop                 ),
		.head   ( head                ),
		.avail  ( avail               ),
		.full   ( fifo_full           )
	);

	// Printer redirection uses FIFO full as busy
	// otherwise busy carries fire of the first extra joystick
	assign parallel_printer_busy = (redir == REDIR_PRINTER) ? fifo_full
	                                                        : joy2[JOY_FIRE_BIT];

	// Directions inverted, bit 0 lands in the nibble MSB
	assign parallel_in = {
		~joy2[0], ~joy2[1], ~joy2[2], ~joy2[3],  // joy2 high nibble
		~joy3[0], ~joy3[1], ~joy3[2], ~joy3[3]   // joy3 low nibble
	};

	assign parallel_in_strobe = ~joy3[JOY_FIRE_BIT];  // joy3 fire on strobe

endmodule

//--- io_fifo.sv
// ----------------------------------------------------------------------
// Single clock byte FIFO
// Writes when full and pops when empty are lost
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module io_fifo import io_cfg_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic  clk_32,
	input  logic  rst_n,
	input  logic  flush,  // Empties the FIFO on core reset
	input  logic  wr,     // One cycle write strobe
	input  byte_t din,
	input  logic  pop,    // Consume head entry
	output byte_t head,   // Oldest entry when avail is high
	output logic  avail,
	output logic  full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	byte_t             mem [DEPTH];  // Entry storage
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;        // Occupancy
	logic              do_wr;
	logic              do_rd;

	assign full  = (count == CNT_W'(DEPTH));
	assign avail = (count != '0);
	assign head  = mem[rd_ptr];  // Next entry shows the cycle after a pop

	assign do_wr = wr & ~full;    // Drop on full
	assign do_rd = pop & avail;   // Ignore on empty

	// Write side storage
	always_ff @(posedge clk_32) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	// Pointer wrap also handles non power of two depths
	always_ff @(posedge clk_32) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

//--- io_xfer_pkg.sv
// ----------------------------------------------------------------------
// Host byte channel types, shared by arbiter and top level
// ----------------------------------------------------------------------
package io_xfer_pkg;

	// Source tag sent along with each host byte
	typedef enum logic {
		CH_MIDI = 1'b0,  // MIDI output FIFO
		CH_PAR  = 1'b1   // Parallel/printer FIFO
	} chan_e;

	// Four-phase handshake FSM
	typedef enum logic [1:0] {
		ARB_IDLE    = 2'd0,  // Waiting for a FIFO with data
		ARB_REQ     = 2'd1,  // host_req high, waiting for ack
		ARB_RELEASE = 2'd2   // req dropped, waiting for ack low
	} arb_state_e;

	// Encoding 2'd3 unused, FSM recovers to idle

endpackage

//--- io_cfg_pkg.sv
// ----------------------------------------------------------------------
// Port widths, FIFO depths and system control word layout
// Redirection field follows the io controller USB target encoding
// ----------------------------------------------------------------------
package io_cfg_pkg;

	localparam int BYTE_W = 8;   // Port data byte
	localparam int CTRL_W = 32;  // System control word from io controller
	localparam int JOY_W  = 16;  // Extra joystick word

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [CTRL_W-1:0] ctrl_word_t;
	typedef logic [JOY_W-1:0]  joy_t;

	// FIFO depths
	localparam int MIDI_FIFO_DEPTH = 16;
	localparam int PAR_FIFO_DEPTH  = 4;   // Small on purpose, busy shows early

	// Control word bit positions
	localparam int CTRL_RESET_BIT = 0;   // Core reset, flushes the byte path
	localparam int CTRL_REDIR_LSB = 26;  // Low bit of 2-bit USB redirection

	localparam int JOY_FIRE_BIT = 4;  // Fire button in a joystick word

	// USB target port usage on io controller
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_RS232   = 2'd1,  // No effect here
		REDIR_PRINTER = 2'd2,  // Busy driven by printer FIFO
		REDIR_MIDI    = 2'd3   // No effect here
	} redir_e;

endpackage
